/* hw/alu.sv */
`timescale 1ns/1ps

module alu
  import core_pkg::*;
(
  input  alu_cmd_t cmd,
  input  word_t    a,
  input  word_t    b,
  output word_t    y
);

  logic [4:0] shamt;

  // shifts use the low five bits only
  assign shamt = b[4:0];

  always_comb begin
    case (cmd)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        y = word_t'($signed(a) >>> shamt);
      end
      // 1 when equal, used by beq
      ALU_EQ: begin
        y = word_t'(a == b);
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

/* hw/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and address width
`define CORE_XLEN 32

// architectural registers, x0 included
`define CORE_NUM_REGS 32

// data memory depth in 32-bit words
`define CORE_DMEM_WORDS 256

`endif

/* hw/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;
  typedef logic [31:0] instr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_EQ
  } alu_cmd_t;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_LBU,
    MEM_LHU,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_access_t;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // instruction word plus the pc it was fetched from
  typedef struct packed {
    instr_t instr;
    word_t  pc;
  } issue_t;

  // everything the execute stage needs
  typedef struct packed {
    alu_cmd_t    alu_cmd;
    mem_access_t mem_access;
    word_t       op1;
    word_t       op2;
    word_t       store_data;
    reg_idx_t    rd;
    logic        rd_we;
    logic        is_branch;
    logic        is_jal;
    word_t       branch_target;
    logic        illegal;
    word_t       pc;
  } decode_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    logic     rd_we;
    word_t    wb_data;
    word_t    next_pc;
    logic     illegal;
  } retire_t;

endpackage

/* hw/core_top.sv */
`timescale 1ns/1ps

module core_top
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    issue_valid,
  input  issue_t  issue,
  output logic    retire_valid,
  output retire_t retire
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  decode_t  dec;

  logic    ex_valid;
  decode_t ex;
  word_t   alu_y;
  word_t   load_data;
  word_t   pc_plus4;
  word_t   wb_data;
  logic    is_load;
  logic    taken;
  retire_t retire_d;

  // decode stage
  instr_decoder u_decoder (
    .issue    (issue),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec)
  );

  register_file u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (ex_valid && ex.rd_we),
    .rd       (ex.rd),
    .wd       (wb_data)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      ex <= dec;
    end
  end

  // execute stage
  alu u_alu (
    .cmd (ex.alu_cmd),
    .a   (ex.op1),
    .b   (ex.op2),
    .y   (alu_y)
  );

  // alu sum is the load/store address
  load_store_unit u_lsu (
    .clk        (clk),
    .arst_n     (arst_n),
    .en         (ex_valid),
    .access     (ex.mem_access),
    .addr       (alu_y),
    .store_data (ex.store_data),
    .load_data  (load_data)
  );

  assign pc_plus4 = ex.pc + word_t'(4);
  assign is_load  = ex.mem_access inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
  assign taken    = ex.is_jal || (ex.is_branch && alu_y == word_t'(1));
  assign wb_data  = is_load ? load_data : ex.is_jal ? pc_plus4 : alu_y;

  always_comb begin
    retire_d.pc      = ex.pc;
    retire_d.rd      = ex.rd;
    retire_d.rd_we   = ex.rd_we;
    retire_d.wb_data = wb_data;
    retire_d.next_pc = taken ? ex.branch_target : pc_plus4;
    retire_d.illegal = ex.illegal;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      retire <= retire_d;
    end
  end

  // fixed two-cycle latency, no stalls anywhere
  a_issue_to_retire: assert property (@(posedge clk) disable iff (!arst_n)
    issue_valid |-> ##2 retire_valid);
  a_retire_from_issue: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> $past(issue_valid, 2));

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
  import core_pkg::*;
(
  input  issue_t   issue,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output decode_t  dec
);

  // don't-care fields for the casez patterns
  localparam logic [4:0]  ANY5  = 'z;
  localparam logic [11:0] ANY12 = 'z;
  localparam logic [24:0] ANY25 = 'z;

  instr_t     instr;
  logic [6:0] opcode;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_cmd_t    alu_cmd;
  mem_access_t mem_access;
  logic        illegal;
  logic        writes_rd;

  assign instr  = issue.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediates, already sign extended to a full word
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // full-encoding match, anything not listed is illegal
  always_comb begin
    alu_cmd    = ALU_ADD;
    mem_access = MEM_NONE;
    illegal    = 1'b0;
    casez (instr)
      {7'b0000000, ANY5, ANY5, 3'b000, ANY5, OPC_R},
      {ANY12, ANY5, 3'b000, ANY5, OPC_IMM},
      {ANY25, OPC_LUI},
      {ANY25, OPC_AUIPC},
      {ANY25, OPC_JAL}:                               alu_cmd = ALU_ADD;
      {7'b0100000, ANY5, ANY5, 3'b000, ANY5, OPC_R}:  alu_cmd = ALU_SUB;
      {7'b0000000, ANY5, ANY5, 3'b100, ANY5, OPC_R},
      {ANY12, ANY5, 3'b100, ANY5, OPC_IMM}:           alu_cmd = ALU_XOR;
      {7'b0000000, ANY5, ANY5, 3'b110, ANY5, OPC_R},
      {ANY12, ANY5, 3'b110, ANY5, OPC_IMM}:           alu_cmd = ALU_OR;
      {7'b0000000, ANY5, ANY5, 3'b111, ANY5, OPC_R},
      {ANY12, ANY5, 3'b111, ANY5, OPC_IMM}:           alu_cmd = ALU_AND;
      {7'b0000000, ANY5, ANY5, 3'b001, ANY5, OPC_R},
      {7'b0000000, ANY5, ANY5, 3'b001, ANY5, OPC_IMM}: alu_cmd = ALU_SLL;
      {7'b0000000, ANY5, ANY5, 3'b101, ANY5, OPC_R},
      {7'b0000000, ANY5, ANY5, 3'b101, ANY5, OPC_IMM}: alu_cmd = ALU_SRL;
      {7'b0100000, ANY5, ANY5, 3'b101, ANY5, OPC_R},
      {7'b0100000, ANY5, ANY5, 3'b101, ANY5, OPC_IMM}: alu_cmd = ALU_SRA;
      {ANY12, ANY5, 3'b000, ANY5, OPC_BRANCH}:        alu_cmd = ALU_EQ;
      {ANY12, ANY5, 3'b000, ANY5, OPC_LOAD}:          mem_access = MEM_LB;
      {ANY12, ANY5, 3'b001, ANY5, OPC_LOAD}:          mem_access = MEM_LH;
      {ANY12, ANY5, 3'b010, ANY5, OPC_LOAD}:          mem_access = MEM_LW;
      {ANY12, ANY5, 3'b100, ANY5, OPC_LOAD}:          mem_access = MEM_LBU;
      {ANY12, ANY5, 3'b101, ANY5, OPC_LOAD}:          mem_access = MEM_LHU;
      {ANY12, ANY5, 3'b000, ANY5, OPC_STORE}:         mem_access = MEM_SB;
      {ANY12, ANY5, 3'b001, ANY5, OPC_STORE}:         mem_access = MEM_SH;
      {ANY12, ANY5, 3'b010, ANY5, OPC_STORE}:         mem_access = MEM_SW;
      default:                                        illegal = 1'b1;
    endcase
  end

  assign writes_rd = opcode inside {OPC_R, OPC_IMM, OPC_LOAD, OPC_LUI, OPC_AUIPC, OPC_JAL};

  always_comb begin
    dec            = '0;
    dec.alu_cmd    = alu_cmd;
    dec.mem_access = mem_access;
    dec.store_data = rs2_data;
    dec.rd         = rd;
    dec.rd_we      = writes_rd && !illegal;
    dec.is_branch  = (opcode == OPC_BRANCH) && !illegal;
    dec.is_jal     = (opcode == OPC_JAL) && !illegal;
    dec.illegal    = illegal;
    dec.pc         = issue.pc;
    // jal jumps by imm_j, beq by imm_b
    dec.branch_target = issue.pc + ((opcode == OPC_JAL) ? imm_j : imm_b);

    // operands per format, alu adds them for address and target forms
    case (opcode)
      OPC_R, OPC_BRANCH: begin
        dec.op1 = rs1_data;
        dec.op2 = rs2_data;
      end
      OPC_IMM, OPC_LOAD: begin
        dec.op1 = rs1_data;
        dec.op2 = imm_i;
      end
      OPC_STORE: begin
        dec.op1 = rs1_data;
        dec.op2 = imm_s;
      end
      OPC_LUI: begin
        dec.op1 = imm_u;
        dec.op2 = '0;
      end
      OPC_AUIPC: begin
        dec.op1 = imm_u;
        dec.op2 = issue.pc;
      end
      OPC_JAL: begin
        dec.op1 = imm_j;
        dec.op2 = issue.pc;
      end
      default: begin
        dec.op1 = '0;
        dec.op2 = '0;
      end
    endcase
  end

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module load_store_unit
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        en,
  input  mem_access_t access,
  input  word_t       addr,
  input  word_t       store_data,
  output word_t       load_data
);

  localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

  word_t            mem [`CORE_DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  word_t            rdata;
  logic [7:0]       byte_sel;
  logic [15:0]      half_sel;
  logic [3:0]       be;
  word_t            wdata;

  // byte offset ignored for the word index
  assign idx   = addr[IDX_W+1:2];
  assign rdata = mem[idx];

  assign byte_sel = rdata[{addr[1:0], 3'b000} +: 8];
  assign half_sel = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (access)
      MEM_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
      MEM_LH:  load_data = {{16{half_sel[15]}}, half_sel};
      MEM_LW:  load_data = rdata;
      MEM_LBU: load_data = {24'h000000, byte_sel};
      MEM_LHU: load_data = {16'h0000, half_sel};
      default: load_data = '0;
    endcase
  end

  // replicate store data across lanes, be picks the ones written
  always_comb begin
    be    = 4'b0000;
    wdata = store_data;
    case (access)
      MEM_SB: begin
        be    = 4'b0001 << addr[1:0];
        wdata = {4{store_data[7:0]}};
      end
      MEM_SH: begin
        be    = addr[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
      end
      MEM_SW: begin
        be = 4'b1111;
      end
      default: begin
        be = 4'b0000;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (en) begin
      for (int l = 0; l < 4; l++) begin
        if (be[l]) begin
          mem[idx][8*l +: 8] <= wdata[8*l +: 8];
        end
      end
    end
  end

  a_addr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    (en && access != MEM_NONE) |-> (addr[`CORE_XLEN-1:2] < `CORE_DMEM_WORDS));

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module register_file
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    wd
);

  word_t regs [`CORE_NUM_REGS];
  logic  wr_en;

  // x0 is never written
  assign wr_en = we && (rd != '0);

  // write-first read so a same-cycle write is seen at once
  assign rs1_data = (wr_en && rd == rs1) ? wd : regs[rs1];
  assign rs2_data = (wr_en && rd == rs2) ? wd : regs[rs2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= wd;
    end
  end

  // x0 reads zero because the write gate never lets regs[0] change
  a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
    ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module core_tb \
  -f sim.f \
  -o core_sim

./obj_dir/core_sim > sim.log 2>&1
cat sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim.f */
+incdir+hw
hw/core_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/load_store_unit.sv
hw/core_top.sv
test/tb_clock_gen.sv
test/core_checker.sv
test/core_tb.sv

/* test/core_checker.sv */
`timescale 1ns/1ps

module core_checker
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    issue_valid,
  input  retire_t expected,
  input  logic    retire_valid,
  input  retire_t retire,
  output int      error_count,
  output int      checked_count,
  output int      pending
);

  retire_t exp_q[$];
  int      issue_cycle_q[$];
  int      cycle = 0;
  int      errors = 0;
  int      checked = 0;
  int      queued = 0;

  assign error_count   = errors;
  assign checked_count = checked;
  assign pending       = queued;

  task automatic compare_field(string name, word_t got, word_t want, word_t pc);
    if (got !== want) begin
      $display("Error at %0d ns: pc %h %s is %h, expected %h", $time, pc, name, got, want);
      errors++;
    end
  endtask

  task automatic check_retire();
    retire_t e;
    int      issued_at;
    if (exp_q.size() == 0) begin
      $display("unexpected retire of pc %h at %0d ns, nothing was outstanding",
               retire.pc, $time);
      errors++;
      return;
    end
    e = exp_q.pop_front();
    issued_at = issue_cycle_q.pop_front();
    checked++;
    if (cycle - issued_at != 2) begin
      $display("retire of pc %h at %0d ns came %0d cycles after issue instead of 2",
               e.pc, $time, cycle - issued_at);
      errors++;
    end
    compare_field("pc", retire.pc, e.pc, e.pc);
    compare_field("rd_we", word_t'(retire.rd_we), word_t'(e.rd_we), e.pc);
    compare_field("next_pc", retire.next_pc, e.next_pc, e.pc);
    compare_field("illegal", word_t'(retire.illegal), word_t'(e.illegal), e.pc);
    // rd and wb_data only mean something when a register is written
    if (e.rd_we) begin
      compare_field("rd", word_t'(retire.rd), word_t'(e.rd), e.pc);
      compare_field("wb_data", retire.wb_data, e.wb_data, e.pc);
    end
  endtask

  // retire at this edge belongs to an issue two edges back, so check first
  always @(posedge clk) begin
    if (arst_n) begin
      cycle++;
      if (retire_valid) begin
        check_retire();
      end
      if (issue_valid) begin
        exp_q.push_back(expected);
        issue_cycle_q.push_back(cycle);
      end
      queued = exp_q.size();
    end
  end

endmodule

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb
  import core_pkg::*;
();

  localparam int CLK_PERIOD_NS = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int SEED          = 19758;

  typedef struct packed {
    issue_t     iss;
    retire_t    exp;
    logic [1:0] max_gap;
  } row_t;

  logic    clk;
  logic    arst_n;
  logic    issue_valid;
  issue_t  issue;
  retire_t expected;
  logic    retire_valid;
  retire_t retire;
  int      error_count;
  int      checked_count;
  int      pending;
  row_t    rows[$];
  word_t   row_pc;
  logic    table_ready = 1'b0;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  core_top DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  core_checker u_checker (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .expected      (expected),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .error_count   (error_count),
    .checked_count (checked_count),
    .pending       (pending)
  );

  // rv32i encoders
  function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic instr_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic instr_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic instr_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic add_row(instr_t instr, reg_idx_t rd, logic rd_we, word_t wb,
                         word_t next_pc, logic illegal, logic [1:0] max_gap);
    row_t r;
    r.iss.instr   = instr;
    r.iss.pc      = row_pc;
    r.exp.pc      = row_pc;
    r.exp.rd      = rd;
    r.exp.rd_we   = rd_we;
    r.exp.wb_data = wb;
    r.exp.next_pc = next_pc;
    r.exp.illegal = illegal;
    r.max_gap     = max_gap;
    rows.push_back(r);
    row_pc = row_pc + 4;
  endtask

  task automatic reg_write_row(instr_t instr, reg_idx_t rd, word_t wb, logic [1:0] max_gap);
    add_row(instr, rd, 1'b1, wb, row_pc + 4, 1'b0, max_gap);
  endtask

  // last column is the largest idle gap before the row, 0 means back to back
  task automatic build_table();
    row_pc = 32'h0000_0100;
    reg_write_row(i_type(12'd5, 0, 3'b000, 1, OPC_IMM), 1, 32'h0000_0005, 3);
    reg_write_row(i_type(12'hffd, 0, 3'b000, 2, OPC_IMM), 2, 32'hffff_fffd, 2);
    // dependent ops back to back through the write-first read
    reg_write_row(r_type(7'h00, 2, 1, 3'b000, 3), 3, 32'h0000_0002, 0);
    reg_write_row(r_type(7'h20, 2, 1, 3'b000, 4), 4, 32'h0000_0008, 0);
    reg_write_row(i_type(12'h0f0, 1, 3'b100, 5, OPC_IMM), 5, 32'h0000_00f5, 3);
    reg_write_row(r_type(7'h00, 4, 5, 3'b110, 6), 6, 32'h0000_00fd, 0);
    reg_write_row(r_type(7'h00, 2, 6, 3'b111, 7), 7, 32'h0000_00fd, 0);
    // shifts, sra of a negative value and shifts by 31
    reg_write_row(i_type(12'h401, 2, 3'b101, 8, OPC_IMM), 8, 32'hffff_fffe, 2);
    reg_write_row(i_type(12'h41f, 2, 3'b101, 9, OPC_IMM), 9, 32'hffff_ffff, 1);
    reg_write_row(i_type(12'h01f, 1, 3'b001, 10, OPC_IMM), 10, 32'h8000_0000, 3);
    reg_write_row(i_type(12'h01f, 10, 3'b101, 11, OPC_IMM), 11, 32'h0000_0001, 0);
    reg_write_row(r_type(7'h00, 1, 2, 3'b101, 12), 12, 32'h07ff_ffff, 2);
    reg_write_row(r_type(7'h20, 1, 2, 3'b101, 13), 13, 32'hffff_ffff, 1);
    reg_write_row(r_type(7'h00, 1, 1, 3'b001, 14), 14, 32'h0000_00a0, 1);
    reg_write_row(i_type(12'h7ff, 1, 3'b110, 15, OPC_IMM), 15, 32'h0000_07ff, 2);
    reg_write_row(i_type(12'h0f0, 2, 3'b111, 16, OPC_IMM), 16, 32'h0000_00f0, 2);
    // x0 drops the write, the next add still reads zero from it
    reg_write_row(i_type(12'd7, 1, 3'b000, 0, OPC_IMM), 0, 32'h0000_000c, 1);
    reg_write_row(r_type(7'h00, 1, 0, 3'b000, 17), 17, 32'h0000_0005, 0);
    reg_write_row(u_type(20'h12345, 18, OPC_LUI), 18, 32'h1234_5000, 3);
    reg_write_row(u_type(20'h00001, 19, OPC_AUIPC), 19, row_pc + 32'h0000_1000, 1);
    reg_write_row(u_type(20'hfffff, 20, OPC_AUIPC), 20, row_pc + 32'hffff_f000, 0);
    // word at 0x40, full store then read back
    reg_write_row(i_type(12'h040, 0, 3'b000, 21, OPC_IMM), 21, 32'h0000_0040, 2);
    reg_write_row(u_type(20'h89abd, 22, OPC_LUI), 22, 32'h89ab_d000, 1);
    reg_write_row(i_type(12'hdef, 22, 3'b000, 22, OPC_IMM), 22, 32'h89ab_cdef, 0);
    add_row(s_type(12'h000, 22, 21, 3'b010), 0, 1'b0, '0, row_pc + 4, 1'b0, 1);
    reg_write_row(i_type(12'h000, 21, 3'b010, 23, OPC_LOAD), 23, 32'h89ab_cdef, 0);
    // merge a half and two bytes, giving ff05_fdef
    add_row(s_type(12'h002, 1, 21, 3'b001), 0, 1'b0, '0, row_pc + 4, 1'b0, 2);
    add_row(s_type(12'h001, 2, 21, 3'b000), 0, 1'b0, '0, row_pc + 4, 1'b0, 0);
    add_row(s_type(12'h003, 15, 21, 3'b000), 0, 1'b0, '0, row_pc + 4, 1'b0, 3);
    reg_write_row(i_type(12'h000, 21, 3'b010, 24, OPC_LOAD), 24, 32'hff05_fdef, 0);
    reg_write_row(i_type(12'h000, 21, 3'b001, 25, OPC_LOAD), 25, 32'hffff_fdef, 1);
    reg_write_row(i_type(12'h000, 21, 3'b101, 26, OPC_LOAD), 26, 32'h0000_fdef, 2);
    reg_write_row(i_type(12'h002, 21, 3'b001, 27, OPC_LOAD), 27, 32'hffff_ff05, 0);
    reg_write_row(i_type(12'h002, 21, 3'b101, 23, OPC_LOAD), 23, 32'h0000_ff05, 1);
    reg_write_row(i_type(12'h001, 21, 3'b000, 28, OPC_LOAD), 28, 32'hffff_fffd, 3);
    reg_write_row(i_type(12'h001, 21, 3'b100, 29, OPC_LOAD), 29, 32'h0000_00fd, 0);
    reg_write_row(i_type(12'h000, 21, 3'b000, 30, OPC_LOAD), 30, 32'hffff_ffef, 1);
    // beq taken, not taken, taken backwards
    add_row(b_type(13'h0010, 17, 1), 0, 1'b0, '0, row_pc + 32'd16, 1'b0, 2);
    add_row(b_type(13'h0010, 2, 1), 0, 1'b0, '0, row_pc + 4, 1'b0, 0);
    add_row(b_type(13'h1ff8, 0, 0), 0, 1'b0, '0, row_pc - 32'd8, 1'b0, 1);
    add_row(j_type(21'h000100, 31), 31, 1'b1, row_pc + 4, row_pc + 32'h100, 1'b0, 2);
    add_row(j_type(21'h1fffe0, 31), 31, 1'b1, row_pc + 4, row_pc - 32'h20, 1'b0, 0);
    // slt, all zeros and a bad funct7, then x1 and x2 must be unchanged
    add_row(r_type(7'h00, 3, 2, 3'b010, 1), 0, 1'b0, '0, row_pc + 4, 1'b1, 2);
    add_row(32'h0000_0000, 0, 1'b0, '0, row_pc + 4, 1'b1, 1);
    add_row(r_type(7'h20, 1, 1, 3'b100, 2), 0, 1'b0, '0, row_pc + 4, 1'b1, 0);
    reg_write_row(r_type(7'h00, 2, 1, 3'b000, 30), 30, 32'h0000_0002, 0);
  endtask

  task automatic print_summary();
    $display("retires checked: %0d, errors: %0d", checked_count, error_count);
  endtask

  initial begin
    int gap;
    issue_valid = 1'b0;
    issue       = '0;
    expected    = '0;
    void'($urandom(SEED));
    build_table();
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    @(posedge clk);
    #1;
    foreach (rows[i]) begin
      gap = $urandom % (int'(rows[i].max_gap) + 1);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      issue_valid = 1'b1;
      issue       = rows[i].iss;
      expected    = rows[i].exp;
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
    end
    wait (pending == 0);
    // a few more edges to catch stray retires
    repeat (4) @(posedge clk);
    print_summary();
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready === 1'b1);
    repeat (rows.size() * 5 + 50) @(posedge clk);
    $display("timeout: run did not finish, %0d expected retires still outstanding", pending);
    print_summary();
    $display("Test FAILED");
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release just after an edge, same as the other stimulus
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule
